// ==== memPkg.sv ====
`default_nettype none

package memPkg;

	// Requester byte address width
	localparam int AddressSize = 24;

	// SRAM word index width, 512 words of 32 bits
	localparam int SramAddressSize = 9;

	// One requester's request as driven from outside
	typedef struct packed {
		logic [AddressSize-1:0] address;
		logic [3:0] byteSelect;
		logic enable;
		logic writeEnable;
		logic [31:0] dataWrite;
	} memRequest_t;

	// Request after range and alignment check
	typedef struct packed {
		logic [SramAddressSize-1:0] wordAddress;
		logic readHit;
		logic writeHit;
		logic [3:0] byteSelect;
		logic [31:0] dataWrite;
	} decodedRequest_t;

	// Read/write port command
	typedef struct packed {
		logic select;
		logic writeEnable;
		logic [SramAddressSize-1:0] address;
		logic [3:0] writeMask;
		logic [31:0] dataWrite;
	} sramRwCmd_t;

	// Read-only port command
	typedef struct packed {
		logic select;
		logic [SramAddressSize-1:0] address;
	} sramRCmd_t;

	typedef enum logic {
		OwnerPrimary = 1'b0,
		OwnerSecondary = 1'b1
	} owner_t;

endpackage

`default_nettype wire

// ==== requestDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module requestDecode import memPkg::*; (
	input wire memRequest_t request,
	output decodedRequest_t decoded
);

	logic aligned;
	logic inRange;
	logic accepted;

	// Word accesses only
	assign aligned = request.address[1:0] == 2'b00;

	// Everything above the word index must be clear
	assign inRange = request.address[AddressSize-1:SramAddressSize+2] == '0;

	// A rejected access simply looks like no access at all
	assign accepted = request.enable && aligned && inRange;

	always_comb begin
		decoded.wordAddress = request.address[SramAddressSize+1:2];
		decoded.readHit = accepted && !request.writeEnable;
		decoded.writeHit = accepted && request.writeEnable;
		decoded.byteSelect = request.byteSelect;
		decoded.dataWrite = request.dataWrite;
	end

endmodule

`default_nettype wire

// ==== portArbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module portArbiter import memPkg::*; (
	input wire clk,
	input wire rst,
	input wire decodedRequest_t primary,
	input wire decodedRequest_t secondary,
	output sramRwCmd_t rwCmd,
	output sramRCmd_t rCmd,
	output logic primaryBusy,
	output logic secondaryBusy,
	output logic primaryDone,
	output logic secondaryDone,
	output logic [3:0] primaryLanes,
	output logic [3:0] secondaryLanes
);

	owner_t owner;
	logic secondaryActive;
	logic rwSelect;
	logic rwComplete;
	logic rSelect;
	logic primaryReadDone;
	logic primaryWriteDone;
	logic secondaryAccessDone;
	logic secondaryReadIssue;

	assign secondaryActive = secondary.readHit || secondary.writeHit;

	// Port is live whenever its current owner wants it
	assign rwSelect = (owner == OwnerSecondary) ? secondaryActive : primary.writeHit;

	// Owner's access finishes in the cycle its done flag is up
	assign rwComplete = (owner == OwnerSecondary) ? secondaryAccessDone : primaryWriteDone;

	// Primary reads never wait, one issue per request
	assign rSelect = primary.readHit && !primaryReadDone;

	assign secondaryReadIssue = rwSelect && owner == OwnerSecondary
		&& !secondary.writeHit && !secondaryAccessDone;

	// Owner may only move when the port is idle or its access just finished
	always_ff @(posedge clk) begin
		if (rst) begin
			owner <= OwnerPrimary;
		end else if (!rwSelect || rwComplete) begin
			if (primary.writeHit) begin
				owner <= OwnerPrimary;
			end else if (secondaryActive) begin
				owner <= OwnerSecondary;
			end
		end
	end

	// Done flags pulse for one cycle so a back-to-back request starts fresh
	always_ff @(posedge clk) begin
		if (rst) begin
			primaryReadDone <= 1'b0;
			primaryWriteDone <= 1'b0;
			secondaryAccessDone <= 1'b0;
		end else begin
			primaryReadDone <= rSelect;
			primaryWriteDone <= rwSelect && owner == OwnerPrimary && !primaryWriteDone;
			secondaryAccessDone <= rwSelect && owner == OwnerSecondary && !secondaryAccessDone;
		end
	end

	// Byte selects of the read in flight
	always_ff @(posedge clk) begin
		if (rSelect) begin
			primaryLanes <= primary.byteSelect;
		end
		if (secondaryReadIssue) begin
			secondaryLanes <= secondary.byteSelect;
		end
	end

	// Read/write port mux by owner
	always_comb begin
		rwCmd.select = rwSelect;
		if (owner == OwnerSecondary) begin
			rwCmd.writeEnable = secondary.writeHit;
			rwCmd.address = secondary.wordAddress;
			rwCmd.writeMask = secondary.byteSelect;
			rwCmd.dataWrite = secondary.dataWrite;
		end else begin
			rwCmd.writeEnable = primary.writeHit;
			rwCmd.address = primary.wordAddress;
			rwCmd.writeMask = primary.byteSelect;
			rwCmd.dataWrite = primary.dataWrite;
		end
	end

	assign rCmd = '{select: rSelect, address: primary.wordAddress};

	// Waiting for the port, or on it but not finished yet
	assign primaryBusy = primary.writeHit && (owner != OwnerPrimary || !primaryWriteDone);
	assign secondaryBusy = secondaryActive
		&& (owner != OwnerSecondary || !secondaryAccessDone);

	// Read issue strobes, data follows one cycle later
	assign primaryDone = rSelect;
	assign secondaryDone = secondaryReadIssue;

endmodule

`default_nettype wire

// ==== readReturn.sv ====
`timescale 1ns/10ps
`default_nettype none

module readReturn (
	input wire clk,
	input wire rst,
	input wire done,
	input wire [3:0] lanes,
	input wire [31:0] readData,
	output logic [31:0] dataRead
);

	logic valid;

	// SRAM data lands one cycle after the issue strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= done;
		end
	end

	// Unselected lanes and idle cycles read as all ones
	always_comb begin
		for (int lane = 0; lane < 4; lane++) begin
			if (valid && lanes[lane]) begin
				dataRead[8*lane +: 8] = readData[8*lane +: 8];
			end else begin
				dataRead[8*lane +: 8] = 8'hff;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sramDualPort.sv ====
`timescale 1ns/10ps
`default_nettype none

module sramDualPort import memPkg::*; (
	input wire clk,
	input wire sramRwCmd_t rwCmd,
	input wire sramRCmd_t rCmd,
	output logic [31:0] rwReadData,
	output logic [31:0] rReadData
);

	logic [31:0] memory [2**SramAddressSize];

	// Model starts out cleared
	initial begin
		for (int i = 0; i < 2**SramAddressSize; i++) begin
			memory[i] = 32'h0;
		end
	end

	// Read/write port, read returns the word as it was before this edge
	always_ff @(posedge clk) begin
		if (rwCmd.select) begin
			rwReadData <= memory[rwCmd.address];
			if (rwCmd.writeEnable) begin
				for (int lane = 0; lane < 4; lane++) begin
					if (rwCmd.writeMask[lane]) begin
						memory[rwCmd.address][8*lane +: 8] <= rwCmd.dataWrite[8*lane +: 8];
					end
				end
			end
		end
	end

	// Read-only port
	always_ff @(posedge clk) begin
		if (rCmd.select) begin
			rReadData <= memory[rCmd.address];
		end
	end

endmodule

`default_nettype wire

// ==== localMemory.sv ====
`timescale 1ns/10ps
`default_nettype none

module localMemory import memPkg::*; (
	input wire clk,
	input wire rst,
	input wire memRequest_t primaryRequest,
	input wire memRequest_t secondaryRequest,
	output logic [31:0] primaryDataRead,
	output logic primaryBusy,
	output logic [31:0] secondaryDataRead,
	output logic secondaryBusy
);

	decodedRequest_t primaryDecoded;
	decodedRequest_t secondaryDecoded;
	sramRwCmd_t rwCmd;
	sramRCmd_t rCmd;
	logic [31:0] rwReadData;
	logic [31:0] rReadData;
	logic primaryDone;
	logic secondaryDone;
	logic [3:0] primaryLanes;
	logic [3:0] secondaryLanes;

	requestDecode i_primaryDecode (
		.request(primaryRequest),
		.decoded(primaryDecoded)
	);

	requestDecode i_secondaryDecode (
		.request(secondaryRequest),
		.decoded(secondaryDecoded)
	);

	portArbiter i_portArbiter (
		.clk(clk),
		.rst(rst),
		.primary(primaryDecoded),
		.secondary(secondaryDecoded),
		.rwCmd(rwCmd),
		.rCmd(rCmd),
		.primaryBusy(primaryBusy),
		.secondaryBusy(secondaryBusy),
		.primaryDone(primaryDone),
		.secondaryDone(secondaryDone),
		.primaryLanes(primaryLanes),
		.secondaryLanes(secondaryLanes)
	);

	// Primary reads come back on the read-only port
	readReturn i_primaryReturn (
		.clk(clk),
		.rst(rst),
		.done(primaryDone),
		.lanes(primaryLanes),
		.readData(rReadData),
		.dataRead(primaryDataRead)
	);

	// Secondary reads come back on the read/write port
	readReturn i_secondaryReturn (
		.clk(clk),
		.rst(rst),
		.done(secondaryDone),
		.lanes(secondaryLanes),
		.readData(rwReadData),
		.dataRead(secondaryDataRead)
	);

	sramDualPort i_sram (
		.clk(clk),
		.rwCmd(rwCmd),
		.rCmd(rCmd),
		.rwReadData(rwReadData),
		.rReadData(rReadData)
	);

endmodule

`default_nettype wire

// ==== tbLocalMemory.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbLocalMemory import memPkg::*; ();

	logic clk;
	logic rst;
	memRequest_t primaryRequest;
	memRequest_t secondaryRequest;
	logic [31:0] primaryDataRead;
	logic [31:0] secondaryDataRead;
	logic primaryBusy;
	logic secondaryBusy;

	// Expected memory contents, updated when a write completes
	logic [31:0] refMemory [2**SramAddressSize];
	logic [31:0] rngState;
	int waitLimit;
	int checkCount;
	int errorCount;
	int testCount;
	int testErrorStart;

	localMemory i_dut (
		.clk(clk),
		.rst(rst),
		.primaryRequest(primaryRequest),
		.secondaryRequest(secondaryRequest),
		.primaryDataRead(primaryDataRead),
		.primaryBusy(primaryBusy),
		.secondaryDataRead(secondaryDataRead),
		.secondaryBusy(secondaryBusy)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic logic [AddressSize-1:0] byteAddress(input int word);
		return AddressSize'(word * 4);
	endfunction

	function automatic memRequest_t makeRequest(input logic [AddressSize-1:0] address,
			input logic [3:0] sel, input logic write, input logic [31:0] data);
		memRequest_t request;
		request.address = address;
		request.byteSelect = sel;
		request.enable = 1'b1;
		request.writeEnable = write;
		request.dataWrite = data;
		return request;
	endfunction

	// Selected lanes come from memory and the rest read as 0xff
	function automatic logic [31:0] expectedRead(input int word, input logic [3:0] sel);
		logic [31:0] value;
		value = 32'hffffffff;
		for (int lane = 0; lane < 4; lane++) begin
			if (sel[lane]) begin
				value[8*lane +: 8] = refMemory[word][8*lane +: 8];
			end
		end
		return value;
	endfunction

	task automatic refWrite(input int word, input logic [3:0] sel, input logic [31:0] data);
		for (int lane = 0; lane < 4; lane++) begin
			if (sel[lane]) begin
				refMemory[word][8*lane +: 8] = data[8*lane +: 8];
			end
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		assert (actual === expected) else begin
			$display("[FAIL] %s got 0x%08h, expected 0x%08h", name, actual, expected);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("Test %0d %s: %0d errors", testCount, name, errorCount - testErrorStart);
		testErrorStart = errorCount;
	endtask

	// Hold the write until busy drops
	task automatic primaryWrite(input logic [AddressSize-1:0] address, input logic [3:0] sel,
			input logic [31:0] data);
		int cycles;
		@(posedge clk);
		primaryRequest <= makeRequest(address, sel, 1'b1, data);
		cycles = 0;
		@(negedge clk);
		while (primaryBusy && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (primaryBusy) begin
			$display("Primary write to 0x%06h never completed", address);
			errorCount++;
		end
		@(posedge clk);
		primaryRequest <= '0;
	endtask

	// Read data shows up in the cycle after the request
	task automatic primaryRead(input logic [AddressSize-1:0] address, input logic [3:0] sel,
			output logic [31:0] data);
		@(posedge clk);
		primaryRequest <= makeRequest(address, sel, 1'b0, 32'h0);
		@(negedge clk);
		checkValue("primaryBusy", 32'(primaryBusy), 32'h0);
		@(negedge clk);
		data = primaryDataRead;
		@(posedge clk);
		primaryRequest <= '0;
	endtask

	task automatic secondaryAccess(input logic [AddressSize-1:0] address, input logic [3:0] sel,
			input logic write, input logic [31:0] data, output logic [31:0] readValue);
		int cycles;
		@(posedge clk);
		secondaryRequest <= makeRequest(address, sel, write, data);
		cycles = 0;
		@(negedge clk);
		while (secondaryBusy && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (secondaryBusy) begin
			$display("Secondary access to 0x%06h never completed", address);
			errorCount++;
		end
		readValue = secondaryDataRead;
		@(posedge clk);
		secondaryRequest <= '0;
	endtask

	task automatic primaryChecked(input int word, input logic [3:0] sel, input logic write,
			input logic [31:0] data);
		logic [31:0] value;
		if (write) begin
			primaryWrite(byteAddress(word), sel, data);
			refWrite(word, sel, data);
		end else begin
			primaryRead(byteAddress(word), sel, value);
			checkValue("primaryDataRead", value, expectedRead(word, sel));
		end
	endtask

	task automatic secondaryChecked(input int word, input logic [3:0] sel, input logic write,
			input logic [31:0] data);
		logic [31:0] value;
		secondaryAccess(byteAddress(word), sel, write, data, value);
		if (write) begin
			refWrite(word, sel, data);
		end else begin
			checkValue("secondaryDataRead", value, expectedRead(word, sel));
		end
	endtask

	// Rejected requests must stay invisible for as long as they are held
	task automatic holdRejected(input memRequest_t primaryReq, input memRequest_t secondaryReq);
		@(posedge clk);
		primaryRequest <= primaryReq;
		secondaryRequest <= secondaryReq;
		repeat (4) begin
			@(negedge clk);
			checkValue("primaryBusy", 32'(primaryBusy), 32'h0);
			checkValue("secondaryBusy", 32'(secondaryBusy), 32'h0);
			checkValue("primaryDataRead", primaryDataRead, 32'hffffffff);
			checkValue("secondaryDataRead", secondaryDataRead, 32'hffffffff);
		end
		@(posedge clk);
		primaryRequest <= '0;
		secondaryRequest <= '0;
	endtask

	initial begin
		logic [31:0] value;
		logic [31:0] dataA;
		logic [31:0] dataB;
		logic [AddressSize-1:0] highBit;
		int wordA;
		int wordB;
		int pool [32];
		int choice;
		int pIndex;
		int sIndex;
		logic [3:0] pSel;
		logic [3:0] sSel;
		logic pWrite;
		logic sWrite;

		clk = 1'b0;
		rst = 1'b1;
		primaryRequest = '0;
		secondaryRequest = '0;
		rngState = 32'ha2d5;
		waitLimit = 20;
		checkCount = 0;
		errorCount = 0;
		testCount = 0;
		testErrorStart = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		@(negedge clk);
		checkValue("primaryBusy", 32'(primaryBusy), 32'h0);
		checkValue("secondaryBusy", 32'(secondaryBusy), 32'h0);
		checkValue("primaryDataRead", primaryDataRead, 32'hffffffff);
		checkValue("secondaryDataRead", secondaryDataRead, 32'hffffffff);
		finishTest("reset state");

		wordA = nextRandom() % 512;
		dataA = nextRandom();
		primaryChecked(wordA, 4'hf, 1'b1, dataA);
		primaryRead(byteAddress(wordA), 4'hf, value);
		checkValue("primaryDataRead", value, dataA);
		finishTest("primary write then read");

		wordB = (wordA + 1 + nextRandom() % 200) % 512;
		primaryChecked(wordB, 4'hf, 1'b1, nextRandom());
		secondaryChecked(wordB, 4'b0101, 1'b1, nextRandom());
		secondaryChecked(wordB, 4'b0110, 1'b0, 32'h0);
		primaryChecked(wordB, 4'hf, 1'b0, 32'h0);
		finishTest("secondary partial write and read");

		dataA = nextRandom();
		dataB = nextRandom();
		fork
			primaryChecked(wordA, 4'hf, 1'b1, dataA);
			secondaryChecked(wordB, 4'hf, 1'b1, dataB);
		join
		fork
			primaryChecked(wordB, 4'hf, 1'b0, 32'h0);
			secondaryChecked(wordA, 4'hf, 1'b0, 32'h0);
		join
		primaryChecked(wordA, 4'hf, 1'b0, 32'h0);
		secondaryChecked(wordB, 4'hf, 1'b0, 32'h0);
		finishTest("concurrent writes");

		// Misaligned and out-of-range addresses that alias wordA and wordB
		highBit = AddressSize'(1) << (SramAddressSize + 2);
		holdRejected(
			makeRequest(byteAddress(wordA) | AddressSize'(1), 4'hf, 1'b1, nextRandom()),
			makeRequest(byteAddress(wordB) | AddressSize'(2), 4'hf, 1'b1, nextRandom()));
		holdRejected(makeRequest(byteAddress(wordA) | (highBit << 9), 4'hf, 1'b0, 32'h0),
			makeRequest(byteAddress(wordB) | highBit, 4'hf, 1'b1, nextRandom()));
		holdRejected(makeRequest(byteAddress(wordB) | highBit, 4'hf, 1'b1, nextRandom()),
			makeRequest(byteAddress(wordA) | AddressSize'(3), 4'hf, 1'b0, 32'h0));
		primaryChecked(wordA, 4'hf, 1'b0, 32'h0);
		primaryChecked(wordB, 4'hf, 1'b0, 32'h0);
		secondaryChecked(wordA, 4'hf, 1'b0, 32'h0);
		finishTest("rejected addresses");

		// Distinct words spread over the array and written before any random read
		for (int i = 0; i < 32; i++) begin
			pool[i] = (i * 37 + 5) % 512;
			primaryChecked(pool[i], 4'hf, 1'b1, nextRandom());
		end
		repeat (60) begin
			choice = nextRandom() % 3;
			pIndex = nextRandom() % 32;
			sIndex = nextRandom() % 32;
			if (sIndex == pIndex) begin
				sIndex = (sIndex + 1) % 32;
			end
			pSel = 4'(nextRandom());
			sSel = 4'(nextRandom());
			pWrite = 1'(nextRandom());
			sWrite = 1'(nextRandom());
			dataA = nextRandom();
			dataB = nextRandom();
			fork
				if (choice != 1) primaryChecked(pool[pIndex], pSel, pWrite, dataA);
				if (choice != 0) secondaryChecked(pool[sIndex], sSel, sWrite, dataB);
			join
		end
		finishTest("random mixed accesses");

		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
memPkg.sv
requestDecode.sv
portArbiter.sv
readReturn.sv
sramDualPort.sv
localMemory.sv
tbLocalMemory.sv
